// ==== source/rv32_cfg.svh ====
`ifndef RV32_CFG_SVH
`define RV32_CFG_SVH

// machine word and address width
`define RV32_XLEN 32

// integer register file
`define RV32_NREGS 32
`define RV32_REG_AW 5

// first fetch address after reset
`define RV32_RESET_PC 32'h20400000

// instruction field widths
`define RV32_OPC_W 7
`define RV32_FUNCT3_W 3
`define RV32_FUNCT7_W 7

`endif

// ==== source/rv32_pkg.sv ====
`include "rv32_cfg.svh"

package rv32_pkg;

    typedef logic [`RV32_XLEN-1:0] word_t;
    typedef logic [`RV32_REG_AW-1:0] reg_idx_t;

    // major opcodes of the kept RV32I subset
    typedef enum logic [`RV32_OPC_W-1:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // encoded as the branch funct3 field
    typedef enum logic [`RV32_FUNCT3_W-1:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_e;

    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_AUIPC,
        KIND_JAL,
        KIND_JALR,
        KIND_BRANCH,
        KIND_NOP
    } instr_kind_e;

endpackage

// ==== source/fetch_if.sv ====
`timescale 1ns/1ps

interface fetch_if;
    import rv32_pkg::*;

    // one-cycle pulse per fetched word
    logic  valid;
    word_t instr;
    word_t pc;

    modport fetch (
        output valid,
        output instr,
        output pc
    );

    modport decode (
        input valid,
        input instr,
        input pc
    );

endinterface

// ==== source/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if;
    import rv32_pkg::*;

    logic        valid;
    instr_kind_e kind;
    alu_op_e     alu_op;
    branch_e     br_cond;
    logic        use_imm;
    reg_idx_t    rd;
    logic        we;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    // sign-extended already
    word_t       imm;
    word_t       pc;

    modport decode (
        output valid, kind, alu_op, br_cond, use_imm,
        output rd, we, rs1, rs2, imm, pc
    );

    modport execute (
        input valid, kind, alu_op, br_cond, use_imm,
        input rd, we, rs1, rs2, imm, pc
    );

endinterface

// ==== source/rv32_fetch.sv ====
`timescale 1ns/1ps

`include "rv32_cfg.svh"

module rv32_fetch (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_ack,
    input  logic            i_stall,
    input  rv32_pkg::word_t i_data,
    input  logic            i_next_valid,
    input  rv32_pkg::word_t i_next_pc,
    output logic            o_cyc,
    output logic            o_stb,
    output rv32_pkg::word_t o_addr,
    fetch_if.fetch          f
);
    import rv32_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e state;
    word_t  pc;
    logic   go;
    logic   done;

    // read completes on ack without stall, in REQ or WAIT
    assign done = o_cyc && i_ack && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= ST_IDLE;
            pc      <= `RV32_RESET_PC;
            go      <= 1'b1;
            f.valid <= 1'b0;
        end else begin
            f.valid <= done;
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_REQ;
                        go    <= 1'b0;
                    end
                end
                ST_REQ: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end else if (!i_stall) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            // redirect lands in pc one cycle before the next request
            if (i_next_valid) begin
                pc <= i_next_pc;
                go <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (done) begin
            f.instr <= i_data;
        end
    end

    assign f.pc   = pc;
    assign o_cyc  = (state != ST_IDLE);
    assign o_stb  = (state == ST_REQ);
    assign o_addr = pc;

endmodule

// ==== source/rv32_decode.sv ====
`timescale 1ns/1ps

`include "rv32_cfg.svh"

module rv32_decode (
    input  logic    i_clk,
    input  logic    i_rst,
    fetch_if.decode f,
    decode_if.decode d
);
    import rv32_pkg::*;

    localparam logic [`RV32_FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [`RV32_FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

    opcode_e                    opcode;
    logic [`RV32_FUNCT3_W-1:0]  funct3;
    logic [`RV32_FUNCT7_W-1:0]  funct7;
    logic                       shift_op;
    word_t                      imm_i;
    word_t                      imm_u;
    word_t                      imm_b;
    word_t                      imm_j;
    instr_kind_e                kind;
    alu_op_e                    alu_op;
    branch_e                    br_cond;
    logic                       use_imm;
    logic                       we;
    word_t                      imm;

    function automatic alu_op_e alu_base(input logic [`RV32_FUNCT3_W-1:0] f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode   = opcode_e'(f.instr[6:0]);
    assign funct3   = f.instr[14:12];
    assign funct7   = f.instr[31:25];
    assign shift_op = (funct3[1:0] == 2'b01);

    assign imm_i = {{20{f.instr[31]}}, f.instr[31:20]};
    assign imm_u = {f.instr[31:12], 12'b0};
    assign imm_b = {{19{f.instr[31]}}, f.instr[31], f.instr[7], f.instr[30:25],
                    f.instr[11:8], 1'b0};
    assign imm_j = {{11{f.instr[31]}}, f.instr[31], f.instr[19:12], f.instr[20],
                    f.instr[30:21], 1'b0};

    // fence, system and unknown opcodes fall through as nop
    always_comb begin
        kind    = KIND_NOP;
        alu_op  = ALU_ADD;
        br_cond = BR_EQ;
        use_imm = 1'b0;
        we      = 1'b0;
        imm     = imm_i;
        case (opcode)
            OPC_LUI: begin
                kind    = KIND_ALU;
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                we      = 1'b1;
                imm     = imm_u;
            end
            OPC_AUIPC: begin
                kind = KIND_AUIPC;
                we   = 1'b1;
                imm  = imm_u;
            end
            OPC_JAL: begin
                kind = KIND_JAL;
                we   = 1'b1;
                imm  = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    kind = KIND_JALR;
                    we   = 1'b1;
                end
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01) begin
                    kind    = KIND_BRANCH;
                    br_cond = branch_e'(funct3);
                    imm     = imm_b;
                end
            end
            OPC_OP_IMM, OPC_OP: begin
                kind    = KIND_ALU;
                we      = 1'b1;
                use_imm = (opcode == OPC_OP_IMM);
                alu_op  = alu_base(funct3);
                // funct7 only matters for register ops and shifts
                if (opcode == OPC_OP || shift_op) begin
                    if (funct7 == F7_ALT && funct3 == 3'b101) begin
                        alu_op = ALU_SRA;
                    end else if (funct7 == F7_ALT && funct3 == 3'b000 && !use_imm) begin
                        alu_op = ALU_SUB;
                    end else if (funct7 != F7_BASE) begin
                        kind = KIND_NOP;
                        we   = 1'b0;
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            d.valid <= 1'b0;
        end else begin
            d.valid <= f.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (f.valid) begin
            d.kind    <= kind;
            d.alu_op  <= alu_op;
            d.br_cond <= br_cond;
            d.use_imm <= use_imm;
            d.we      <= we;
            d.rd      <= f.instr[11:7];
            d.rs1     <= f.instr[19:15];
            d.rs2     <= f.instr[24:20];
            d.imm     <= imm;
            d.pc      <= f.pc;
        end
    end

endmodule

// ==== source/rv32_regfile.sv ====
`timescale 1ns/1ps

`include "rv32_cfg.svh"

module rv32_regfile (
    input  logic               i_clk,
    input  logic               i_rst,
    input  rv32_pkg::reg_idx_t i_rs1,
    input  rv32_pkg::reg_idx_t i_rs2,
    input  logic               i_we,
    input  rv32_pkg::reg_idx_t i_rd,
    input  rv32_pkg::word_t    i_wd,
    output rv32_pkg::word_t    o_rs1_data,
    output rv32_pkg::word_t    o_rs2_data
);
    import rv32_pkg::*;

    word_t regs [`RV32_NREGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV32_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wd;
        end
    end

    // x0 reads as zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== source/rv32_execute.sv ====
`timescale 1ns/1ps

module rv32_execute (
    decode_if.execute          d,
    output rv32_pkg::reg_idx_t o_rs1,
    output rv32_pkg::reg_idx_t o_rs2,
    output logic               o_we,
    output rv32_pkg::reg_idx_t o_rd,
    output rv32_pkg::word_t    o_wd,
    output logic               o_next_valid,
    output rv32_pkg::word_t    o_next_pc,
    input  rv32_pkg::word_t    i_rs1_data,
    input  rv32_pkg::word_t    i_rs2_data
);
    import rv32_pkg::*;

    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_res;
    logic       taken;
    word_t      pc_plus4;
    word_t      pc_imm;
    word_t      jalr_sum;

    assign op_b     = d.use_imm ? d.imm : i_rs2_data;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = d.pc + 32'd4;
    assign pc_imm   = d.pc + d.imm;
    assign jalr_sum = i_rs1_data + d.imm;

    always_comb begin
        case (d.alu_op)
            ALU_ADD:    alu_res = i_rs1_data + op_b;
            ALU_SUB:    alu_res = i_rs1_data - op_b;
            ALU_SLL:    alu_res = i_rs1_data << shamt;
            ALU_SLT:    alu_res = word_t'($signed(i_rs1_data) < $signed(op_b));
            ALU_SLTU:   alu_res = word_t'(i_rs1_data < op_b);
            ALU_XOR:    alu_res = i_rs1_data ^ op_b;
            ALU_SRL:    alu_res = i_rs1_data >> shamt;
            ALU_SRA:    alu_res = word_t'($signed(i_rs1_data) >>> shamt);
            ALU_OR:     alu_res = i_rs1_data | op_b;
            ALU_AND:    alu_res = i_rs1_data & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // branches always compare two registers
    always_comb begin
        case (d.br_cond)
            BR_EQ:   taken = (i_rs1_data == i_rs2_data);
            BR_NE:   taken = (i_rs1_data != i_rs2_data);
            BR_LT:   taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            BR_GE:   taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            BR_LTU:  taken = (i_rs1_data < i_rs2_data);
            BR_GEU:  taken = (i_rs1_data >= i_rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (d.kind)
            KIND_AUIPC:          o_wd = pc_imm;
            KIND_JAL, KIND_JALR: o_wd = pc_plus4;
            default:             o_wd = alu_res;
        endcase
    end

    always_comb begin
        o_next_pc = pc_plus4;
        case (d.kind)
            KIND_JAL:    o_next_pc = pc_imm;
            KIND_JALR:   o_next_pc = jalr_sum & ~32'd1;
            KIND_BRANCH: begin
                if (taken) begin
                    o_next_pc = pc_imm;
                end
            end
            default: ;
        endcase
    end

    assign o_rs1        = d.rs1;
    assign o_rs2        = d.rs2;
    assign o_rd         = d.rd;
    // nop kinds arrive with we already low
    assign o_we         = d.valid && d.we;
    assign o_next_valid = d.valid;

endmodule

// ==== source/rv32_core.sv ====
`timescale 1ns/1ps

module rv32_core (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_ack,
    input  logic            i_stall,
    input  rv32_pkg::word_t i_data,
    output logic            o_cyc,
    output logic            o_stb,
    output rv32_pkg::word_t o_addr
);
    import rv32_pkg::*;

    fetch_if  fetch_bus ();
    decode_if decode_bus ();

    logic     next_valid;
    word_t    next_pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     we;
    word_t    wd;
    word_t    rs1_data;
    word_t    rs2_data;

    rv32_fetch fetch_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_ack        (i_ack),
        .i_stall      (i_stall),
        .i_data       (i_data),
        .i_next_valid (next_valid),
        .i_next_pc    (next_pc),
        .o_cyc        (o_cyc),
        .o_stb        (o_stb),
        .o_addr       (o_addr),
        .f            (fetch_bus)
    );

    rv32_decode decode_i (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .f     (fetch_bus),
        .d     (decode_bus)
    );

    rv32_execute execute_i (
        .d            (decode_bus),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_we         (we),
        .o_rd         (rd),
        .o_wd         (wd),
        .o_next_valid (next_valid),
        .o_next_pc    (next_pc),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data)
    );

    rv32_regfile regfile_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_we       (we),
        .i_rd       (rd),
        .i_wd       (wd),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 10
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

    // reset covers the first two rising edges
    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        #1 o_rst = 1'b0;
    end

endmodule

// ==== tests/rv32_iss.svh ====
`ifndef RV32_ISS_SVH
`define RV32_ISS_SVH

integer seed;
word_t  xr [32];
word_t  model_pc;

task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
        xr[i] = '0;
    end
    model_pc = `RV32_RESET_PC;
endtask

function automatic word_t rand_word();
    word_t w;
    w = $random(seed);
    return w;
endfunction

// small register set so results feed later compares and jalr bases
function automatic reg_idx_t rand_reg();
    word_t w;
    w = rand_word();
    return {2'b00, w[2:0]};
endfunction

function automatic logic [6:0] pick_funct7();
    word_t w;
    w = rand_word();
    case (w[2:0])
        3'd5, 3'd6: return 7'h20;
        3'd7:       return w[14:8];
        default:    return 7'h00;
    endcase
endfunction

function automatic word_t make_instr();
    word_t      r;
    word_t      fld;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] f3;
    r   = rand_word();
    fld = rand_word();
    rd  = rand_reg();
    rs1 = rand_reg();
    rs2 = rand_reg();
    f3  = fld[2:0];
    case (fld[7:4])
        4'd0:       return {r[31:12], rd, OPC_LUI};
        4'd1:       return {r[31:12], rd, OPC_AUIPC};
        4'd2:       return {r[31:12], rd, OPC_JAL};
        4'd3:       return {r[31:20], rs1, (fld[10:8] == 3'd0) ? fld[13:11] : 3'b000, rd,
                            OPC_JALR};
        4'd4, 4'd5: return {r[31:25], rs2, rs1, f3, r[11:7], OPC_BRANCH};
        4'd6, 4'd7,
        4'd8:       return {r[31:20], rs1, f3, rd, OPC_OP_IMM};
        4'd11:      return {pick_funct7(), r[24:20], rs1, fld[3] ? 3'b101 : 3'b001, rd,
                            OPC_OP_IMM};
        4'd12:      return {r[31:15], f3, r[11:7], OPC_MISC_MEM};
        4'd13:      return {r[31:15], f3, r[11:7], OPC_SYSTEM};
        // mostly opcodes the core does not know
        4'd14:      return r;
        default:    return {pick_funct7(), rs2, rs1, f3, rd, OPC_OP};
    endcase
endfunction

function automatic logic alu_legal(input logic [2:0] f3, input logic [6:0] f7,
                                   input logic is_imm);
    if (is_imm && f3 != 3'b001 && f3 != 3'b101) begin
        return 1'b1;
    end
    if (f7 == 7'h00) begin
        return 1'b1;
    end
    return (f7 == 7'h20) && (f3 == 3'b101 || (f3 == 3'b000 && !is_imm));
endfunction

function automatic word_t alu_calc(input logic [2:0] f3, input logic alt,
                                   input word_t a, input word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic run_model(input word_t ins);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    word_t      res;
    word_t      next;
    logic       wr;
    logic       is_imm;
    logic       alt;
    op     = ins[6:0];
    f3     = ins[14:12];
    f7     = ins[31:25];
    a      = xr[ins[19:15]];
    b      = xr[ins[24:20]];
    imm_i  = {{20{ins[31]}}, ins[31:20]};
    imm_u  = {ins[31:12], 12'b0};
    imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    res    = '0;
    wr     = 1'b0;
    next   = model_pc + 32'd4;
    is_imm = (op == OPC_OP_IMM);
    case (op)
        OPC_LUI: begin
            res = imm_u;
            wr  = 1'b1;
        end
        OPC_AUIPC: begin
            res = model_pc + imm_u;
            wr  = 1'b1;
        end
        OPC_JAL: begin
            res  = model_pc + 32'd4;
            next = model_pc + imm_j;
            wr   = 1'b1;
        end
        OPC_JALR: begin
            if (f3 == 3'b000) begin
                res  = model_pc + 32'd4;
                next = (a + imm_i) & ~32'd1;
                wr   = 1'b1;
            end
        end
        OPC_BRANCH: begin
            // funct3 010 and 011 are reserved
            if (f3[2:1] != 2'b01 && branch_taken(f3, a, b)) begin
                next = model_pc + imm_b;
            end
        end
        OPC_OP_IMM, OPC_OP: begin
            if (alu_legal(f3, f7, is_imm)) begin
                alt = (f7 == 7'h20) && (f3 == 3'b101 || !is_imm);
                res = alu_calc(f3, alt, a, is_imm ? imm_i : b);
                wr  = 1'b1;
            end
        end
        default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
        xr[ins[11:7]] = res;
    end
    model_pc = next;
endtask

`endif

// ==== tests/tb_rv32_core.sv ====
`timescale 1ns/1ps

`include "rv32_cfg.svh"

module tb_rv32_core;
    import rv32_pkg::*;

    localparam int NUM_INSTR  = 2000;
    localparam int MAX_CYCLES = NUM_INSTR * 12;

    logic  clk;
    logic  rst;
    logic  ack;
    logic  stall;
    word_t data;
    logic  cyc;
    logic  stb;
    word_t addr;

    `include "rv32_iss.svh"

    tb_clock clock_i (
        .o_clk (clk),
        .o_rst (rst)
    );

    rv32_core rv32_core_i (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_ack   (ack),
        .i_stall (stall),
        .i_data  (data),
        .o_cyc   (cyc),
        .o_stb   (stb),
        .o_addr  (addr)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    // bus responder and checks, one pass per cycle at 1 ns after the edge
    initial begin
        word_t      instr;
        word_t      req_addr;
        word_t      r;
        int         done_count;
        int         cycles;
        int         since_ack;
        logic       busy;
        logic       accepted;
        logic       prev_stb;
        logic       seen_ack;
        logic [1:0] ack_cnt;
        ack        = 1'b0;
        stall      = 1'b0;
        data       = '0;
        seed       = 32'h9234ea47;
        instr      = '0;
        req_addr   = '0;
        done_count = 0;
        cycles     = 0;
        since_ack  = 0;
        busy       = 1'b0;
        accepted   = 1'b0;
        prev_stb   = 1'b0;
        seen_ack   = 1'b0;
        ack_cnt    = '0;
        reset_model();

        @(negedge rst);
        assert (!cyc && !stb) else report_error("bus request active during reset");
        @(posedge clk);
        #1;
        assert (stb) else report_error("no request one cycle after reset release");

        while (done_count < NUM_INSTR) begin
            cycles++;
            since_ack++;
            assert (cycles < MAX_CYCLES) else report_error("run timed out");
            if (stb && !prev_stb) begin
                assert (!busy) else report_error("second request while one is outstanding");
                assert (addr == model_pc) else report_error(
                    $sformatf("FAILED o_addr expected %h actual %h", model_pc, addr));
                if (seen_ack) begin
                    assert (since_ack == 4) else report_error(
                        $sformatf("request came %0d cycles after the ack, not 4", since_ack));
                end
                busy     = 1'b1;
                accepted = 1'b0;
                req_addr = addr;
                instr    = make_instr();
            end
            if (busy) begin
                assert (cyc) else report_error("o_cyc dropped before the accepting ack");
                assert (addr == req_addr) else report_error(
                    $sformatf("FAILED o_addr expected %h actual %h", req_addr, addr));
                assert (stb == !accepted) else report_error(
                    $sformatf("FAILED o_stb expected %h actual %h", !accepted, stb));
            end else begin
                assert (!cyc && !stb) else report_error("bus active with no request");
            end
            prev_stb = stb;

            // stall about one cycle in four, ack 0 to 3 cycles after acceptance
            r     = rand_word();
            stall = (r[1:0] == 2'b00);
            ack   = 1'b0;
            if (busy && !accepted && !stall) begin
                accepted = 1'b1;
                ack_cnt  = r[3:2];
            end
            if (busy && accepted) begin
                if (ack_cnt == 2'd0) begin
                    ack = 1'b1;
                end else begin
                    ack_cnt--;
                end
            end
            data = ack ? instr : rand_word();
            if (ack && !stall) begin
                run_model(instr);
                busy      = 1'b0;
                seen_ack  = 1'b1;
                since_ack = 0;
                done_count++;
            end
            @(posedge clk);
            #1;
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
+incdir+tests
source/rv32_pkg.sv
source/fetch_if.sv
source/decode_if.sv
source/rv32_fetch.sv
source/rv32_decode.sv
source/rv32_regfile.sv
source/rv32_execute.sv
source/rv32_core.sv
tests/tb_clock.sv
tests/tb_rv32_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv32_core -f verilog.f -o sim_rv32

./obj_dir/sim_rv32 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
echo "simulation finished without errors"
